// File: logic/icb_bridge_params.svh
// ========================================
// widths and queue depth for the ICB unaligned bridge
// include wherever these values are needed
// ========================================
`ifndef ICB_BRIDGE_PARAMS_SVH
`define ICB_BRIDGE_PARAMS_SVH

// bus widths
`define ICB_DATA_W 32
`define ICB_ADDR_W 32
// burst length field, holds beats minus one
`define ICB_LEN_W 3

// outstanding upstream commands, power of two
`define ICB_QUEUE_DEPTH 8
// error region of the memory model, address bit 12 set
`define ICB_ERR_BASE 32'h0000_1000
`endif

// File: logic/icb_bridge_pkg.sv
// ========================================
// shared types of the ICB unaligned bridge
// import in the module header where used
// ========================================
`include "icb_bridge_params.svh"

package icb_bridge_pkg;

  // byte address and data word
  typedef logic [`ICB_ADDR_W-1:0] icb_addr_t;
  typedef logic [`ICB_DATA_W-1:0] icb_data_t;
  // one enable bit per byte lane
  typedef logic [`ICB_DATA_W/8-1:0] icb_mask_t;
  // burst length minus one
  typedef logic [`ICB_LEN_W-1:0] icb_len_t;
  // start offset inside a word
  typedef logic [1:0] byte_off_t;
  // downstream beats of one request, up to len + 2
  typedef logic [`ICB_LEN_W:0] beat_cnt_t;

  // beat sequencer FSM
  typedef enum logic {SEQ_IDLE, SEQ_RUN} seq_state_t;

  // response merger FSM
  // first word of an unaligned read is absorbed in MERGE_FIRST
  typedef enum logic [1:0] {MERGE_IDLE, MERGE_FIRST, MERGE_RUN} merge_state_t;

endpackage

// File: logic/icb_cmd_queue.sv
// ========================================
// outstanding command FIFO of the bridge
// pops the head once sequencer and merger are idle
// ========================================
`include "icb_bridge_params.svh"

module icb_cmd_queue import icb_bridge_pkg::*; #(
  parameter int DEPTH = `ICB_QUEUE_DEPTH
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      sa_cmd_valid,
  output logic      sa_cmd_ready,
  input  icb_addr_t sa_cmd_addr,
  input  logic      sa_cmd_read,
  input  icb_len_t  sa_cmd_len,
  input  logic      seq_idle,
  input  logic      merge_idle,
  output logic      pop,
  output icb_addr_t head_addr,
  output logic      head_read,
  output icb_len_t  head_len
);

  localparam int PTR_W = $clog2(DEPTH);

  // storage, one entry per accepted command
  icb_addr_t        q_addr [DEPTH];
  logic             q_read [DEPTH];
  icb_len_t         q_len  [DEPTH];

  // extra msb is the wrap bit
  logic [PTR_W:0]   wptr;
  logic [PTR_W:0]   rptr;
  logic             full;
  logic             head_valid;
  logic             push;

  assign full = (wptr[PTR_W] != rptr[PTR_W]) && (wptr[PTR_W-1:0] == rptr[PTR_W-1:0]);
  assign head_valid = (wptr != rptr);

  assign sa_cmd_ready = !full;
  assign push = sa_cmd_valid && !full;
  // one transaction at a time
  assign pop = head_valid && seq_idle && merge_idle;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (push) wptr <= wptr + 1'b1;
      if (pop) rptr <= rptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q_addr[wptr[PTR_W-1:0]] <= sa_cmd_addr;
      q_read[wptr[PTR_W-1:0]] <= sa_cmd_read;
      q_len[wptr[PTR_W-1:0]]  <= sa_cmd_len;
    end
  end

  // head shown combinationally
  assign head_addr = q_addr[rptr[PTR_W-1:0]];
  assign head_read = q_read[rptr[PTR_W-1:0]];
  assign head_len  = q_len[rptr[PTR_W-1:0]];

endmodule

// File: logic/icb_beat_sequencer.sv
// ========================================
// issues aligned downstream beats for one request
// and realigns write data and byte masks
// ========================================
module icb_beat_sequencer import icb_bridge_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      pop,
  input  icb_addr_t head_addr,
  input  logic      head_read,
  input  icb_len_t  head_len,
  input  logic      sa_w_valid,
  output logic      sa_w_ready,
  input  icb_data_t sa_wdata,
  input  icb_mask_t sa_wmask,
  output logic      m_cmd_valid,
  input  logic      m_cmd_ready,
  output icb_addr_t m_cmd_addr,
  output logic      m_cmd_read,
  output icb_data_t m_cmd_wdata,
  output icb_mask_t m_cmd_wmask,
  output logic      seq_idle
);

  localparam int DW = $bits(icb_data_t);
  localparam int MW = $bits(icb_mask_t);

  seq_state_t          state;
  // latched request
  icb_addr_t           base_addr;
  byte_off_t           off;
  logic                is_read;
  beat_cnt_t           total;
  beat_cnt_t           beat;
  // high part carried into the next beat
  icb_data_t           wbuf;
  icb_mask_t           wmask_buf;

  logic                last_beat;
  logic                tail_beat;
  logic                cmd_fire;
  logic [4:0]          sh;
  logic [2*DW-1:0]     wide_data;
  logic [2*MW-1:0]     wide_mask;

  // ========================================
  // beat control
  // ========================================
  assign last_beat = (beat == total - beat_cnt_t'(1));
  // unaligned write ends with the saved part only
  assign tail_beat = !is_read && (off != 2'b00) && last_beat;

  assign m_cmd_valid = (state == SEQ_RUN) && (is_read || tail_beat || sa_w_valid);
  // write data moves only together with a downstream beat
  assign sa_w_ready = (state == SEQ_RUN) && !is_read && !tail_beat && m_cmd_ready;
  assign cmd_fire = m_cmd_valid && m_cmd_ready;

  assign m_cmd_addr = base_addr + (icb_addr_t'(beat) << 2);
  assign m_cmd_read = is_read;
  assign seq_idle = (state == SEQ_IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= SEQ_IDLE;
      base_addr <= '0;
      off <= '0;
      is_read <= 1'b0;
      total <= '0;
      beat <= '0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (pop) begin
            state <= SEQ_RUN;
            base_addr <= {head_addr[$bits(icb_addr_t)-1:2], 2'b00};
            off <= head_addr[1:0];
            is_read <= head_read;
            // one extra beat when the start is unaligned
            total <= beat_cnt_t'(head_len) + beat_cnt_t'(1) +
                     beat_cnt_t'(head_addr[1:0] != 2'b00);
            beat <= '0;
          end
        end
        SEQ_RUN: begin
          if (cmd_fire) begin
            if (last_beat) state <= SEQ_IDLE;
            else beat <= beat + beat_cnt_t'(1);
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // ========================================
  // write realignment
  // ========================================
  assign sh = {off, 3'b000};
  // low half goes out now, high half waits for the next beat
  assign wide_data = {{DW{1'b0}}, sa_wdata} << sh;
  assign wide_mask = {{MW{1'b0}}, sa_wmask} << off;

  always_ff @(posedge clk) begin
    if (pop && state == SEQ_IDLE) begin
      wbuf <= '0;
      wmask_buf <= '0;
    end else if (cmd_fire && !is_read && !tail_beat) begin
      wbuf <= wide_data[2*DW-1:DW];
      wmask_buf <= wide_mask[2*MW-1:MW];
    end
  end

  always_comb begin
    m_cmd_wdata = '0;
    m_cmd_wmask = '0;
    if (!is_read) begin
      if (tail_beat) begin
        m_cmd_wdata = wbuf;
        m_cmd_wmask = wmask_buf;
      end else begin
        m_cmd_wdata = wide_data[DW-1:0] | wbuf;
        m_cmd_wmask = wide_mask[MW-1:0] | wmask_buf;
      end
    end
  end

endmodule

// File: logic/icb_rsp_merger.sv
// ========================================
// counts downstream responses, merges read words
// and gates the upstream response channel
// ========================================
module icb_rsp_merger import icb_bridge_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      pop,
  input  icb_addr_t head_addr,
  input  logic      head_read,
  input  icb_len_t  head_len,
  input  logic      m_rsp_valid,
  output logic      m_rsp_ready,
  input  icb_data_t m_rsp_rdata,
  input  logic      m_rsp_err,
  output logic      sa_rsp_valid,
  input  logic      sa_rsp_ready,
  output icb_data_t sa_rsp_rdata,
  output logic      sa_rsp_err,
  output logic      merge_idle
);

  localparam int DW = $bits(icb_data_t);

  merge_state_t        state;
  byte_off_t           off;
  logic                is_read;
  beat_cnt_t           total;
  beat_cnt_t           cnt;
  // previous downstream word and the error carried with it
  icb_data_t           rbuf;
  logic                err_acc;

  logic                last_rsp;
  logic                emit;
  logic                rsp_fire;
  logic                err_carry;
  logic [2*DW-1:0]     wide_rd;

  assign last_rsp = (cnt == total - beat_cnt_t'(1));
  // reads answer every beat after the first, writes only the last one
  assign emit = (state == MERGE_RUN) && (is_read || last_rsp);

  assign sa_rsp_valid = m_rsp_valid && emit;
  // absorbed responses are always taken
  assign m_rsp_ready = emit ? sa_rsp_ready : 1'b1;
  assign rsp_fire = m_rsp_valid && m_rsp_ready && (state != MERGE_IDLE);
  assign merge_idle = (state == MERGE_IDLE);

  // ========================================
  // data and error
  // ========================================
  assign wide_rd = {m_rsp_rdata, rbuf} >> {off, 3'b000};

  always_comb begin
    sa_rsp_rdata = '0;
    if (is_read) begin
      if (off == 2'b00) sa_rsp_rdata = m_rsp_rdata;
      else sa_rsp_rdata = wide_rd[DW-1:0];
    end
  end

  assign sa_rsp_err = err_acc | m_rsp_err;

  // unaligned reads keep the error of the buffered word
  // writes collect all beats, aligned reads need nothing
  always_comb begin
    if (!is_read) err_carry = err_acc | m_rsp_err;
    else if (off != 2'b00) err_carry = m_rsp_err;
    else err_carry = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rsp_fire) rbuf <= m_rsp_rdata;
  end

  // ========================================
  // FSM
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= MERGE_IDLE;
      off <= '0;
      is_read <= 1'b0;
      total <= '0;
      cnt <= '0;
      err_acc <= 1'b0;
    end else begin
      case (state)
        MERGE_IDLE: begin
          if (pop) begin
            off <= head_addr[1:0];
            is_read <= head_read;
            total <= beat_cnt_t'(head_len) + beat_cnt_t'(1) +
                     beat_cnt_t'(head_addr[1:0] != 2'b00);
            cnt <= '0;
            err_acc <= 1'b0;
            if (head_read && head_addr[1:0] != 2'b00) state <= MERGE_FIRST;
            else state <= MERGE_RUN;
          end
        end
        MERGE_FIRST: begin
          if (rsp_fire) begin
            state <= MERGE_RUN;
            cnt <= cnt + beat_cnt_t'(1);
            err_acc <= err_carry;
          end
        end
        MERGE_RUN: begin
          if (rsp_fire) begin
            if (last_rsp) begin
              state <= MERGE_IDLE;
              err_acc <= 1'b0;
            end else begin
              cnt <= cnt + beat_cnt_t'(1);
              err_acc <= err_carry;
            end
          end
        end
        default: state <= MERGE_IDLE;
      endcase
    end
  end

endmodule

// File: logic/icb_unalign_bridge.sv
// ========================================
// ICB bridge from unaligned bursts to aligned beats
// slave port sa_*, master port m_*
// ========================================
module icb_unalign_bridge import icb_bridge_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // upstream command
  input  logic      sa_cmd_valid,
  output logic      sa_cmd_ready,
  input  icb_addr_t sa_cmd_addr,
  input  logic      sa_cmd_read,
  input  icb_len_t  sa_cmd_len,
  // upstream write data
  input  logic      sa_w_valid,
  output logic      sa_w_ready,
  input  icb_data_t sa_wdata,
  input  icb_mask_t sa_wmask,
  // upstream response
  output logic      sa_rsp_valid,
  input  logic      sa_rsp_ready,
  output icb_data_t sa_rsp_rdata,
  output logic      sa_rsp_err,
  // downstream command
  output logic      m_cmd_valid,
  input  logic      m_cmd_ready,
  output icb_addr_t m_cmd_addr,
  output logic      m_cmd_read,
  output icb_data_t m_cmd_wdata,
  output icb_mask_t m_cmd_wmask,
  // downstream response
  input  logic      m_rsp_valid,
  output logic      m_rsp_ready,
  input  icb_data_t m_rsp_rdata,
  input  logic      m_rsp_err
);

  // queue head, latched by both partners on pop
  logic      pop;
  icb_addr_t head_addr;
  logic      head_read;
  icb_len_t  head_len;
  logic      seq_idle;
  logic      merge_idle;

  icb_cmd_queue u_queue (
    .clk, .rst_n, .sa_cmd_valid, .sa_cmd_ready, .sa_cmd_addr, .sa_cmd_read,
    .sa_cmd_len, .seq_idle, .merge_idle, .pop, .head_addr, .head_read, .head_len
  );

  icb_beat_sequencer u_seq (
    .clk, .rst_n, .pop, .head_addr, .head_read, .head_len,
    .sa_w_valid, .sa_w_ready, .sa_wdata, .sa_wmask,
    .m_cmd_valid, .m_cmd_ready, .m_cmd_addr, .m_cmd_read, .m_cmd_wdata, .m_cmd_wmask,
    .seq_idle
  );

  // response path is combinational end to end
  icb_rsp_merger u_merge (
    .clk, .rst_n, .pop, .head_addr, .head_read, .head_len,
    .m_rsp_valid, .m_rsp_ready, .m_rsp_rdata, .m_rsp_err,
    .sa_rsp_valid, .sa_rsp_ready, .sa_rsp_rdata, .sa_rsp_err,
    .merge_idle
  );

endmodule

// File: test/icb_mem_model.sv
// ========================================
// downstream ICB memory for the testbench
// random ready and response delay, error region flagged
// ========================================
`include "icb_bridge_params.svh"

module icb_mem_model import icb_bridge_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      m_cmd_valid,
  output logic      m_cmd_ready,
  input  icb_addr_t m_cmd_addr,
  input  logic      m_cmd_read,
  input  icb_data_t m_cmd_wdata,
  input  icb_mask_t m_cmd_wmask,
  output logic      m_rsp_valid,
  input  logic      m_rsp_ready,
  output icb_data_t m_rsp_rdata,
  output logic      m_rsp_err
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0] mem [8192];
  // responses in command order
  icb_data_t  rdata_q [$];
  logic       err_q [$];
  logic       rsp_taken;
  int         delay;

  initial begin
    m_cmd_ready = 1'b0;
    m_rsp_valid = 1'b0;
    m_rsp_rdata = '0;
    m_rsp_err = 1'b0;
    rsp_taken = 1'b0;
    delay = 0;
    // fill depends on every address bit
    for (int a = 0; a < 8192; a++) begin
      mem[a] = 8'(a * 13 + (a >> 7));
    end
  end

  // accept commands on the rising edge
  always @(posedge clk) begin
    icb_data_t word;
    int idx;
    if (rst_n && m_cmd_valid && m_cmd_ready) begin
      for (int b = 0; b < 4; b++) begin
        idx = int'({m_cmd_addr[12:2], 2'b00}) + b;
        word[8*b +: 8] = mem[idx];
        if (!m_cmd_read && m_cmd_wmask[b]) begin
          mem[idx] = m_cmd_wdata[8*b +: 8];
        end
      end
      rdata_q.push_back(m_cmd_read ? word : '0);
      err_q.push_back((m_cmd_addr & `ICB_ERR_BASE) != 0);
    end
    rsp_taken <= rst_n && m_rsp_valid && m_rsp_ready;
  end

  // outputs change on the falling edge only
  always @(negedge clk) begin
    if (!rst_n) begin
      m_cmd_ready = 1'b0;
      m_rsp_valid = 1'b0;
    end else begin
      m_cmd_ready = ($urandom % 4) != 0;
      if (rsp_taken) begin
        rdata_q.delete(0);
        err_q.delete(0);
        m_rsp_valid = 1'b0;
        delay = $urandom % 3;
      end
      if (!m_rsp_valid && rdata_q.size() > 0) begin
        if (delay > 0) begin
          delay--;
        end else begin
          m_rsp_valid = 1'b1;
          m_rsp_rdata = rdata_q[0];
          m_rsp_err = err_q[0];
        end
      end
    end
  end

endmodule

// File: test/tb_icb_bridge.sv
// ========================================
// random upstream bursts against a byte model of memory
// checks read data, errors and downstream addresses
// ========================================
`include "icb_bridge_params.svh"

module tb_icb_bridge import icb_bridge_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  logic clk = 1'b0;
  logic rst_n;
  logic sa_cmd_valid, sa_cmd_ready, sa_cmd_read;
  icb_addr_t sa_cmd_addr;
  icb_len_t sa_cmd_len;
  logic sa_w_valid, sa_w_ready;
  icb_data_t sa_wdata;
  icb_mask_t sa_wmask;
  logic sa_rsp_valid, sa_rsp_ready, sa_rsp_err;
  icb_data_t sa_rsp_rdata;
  logic m_cmd_valid, m_cmd_ready, m_cmd_read;
  icb_addr_t m_cmd_addr;
  icb_data_t m_cmd_wdata;
  icb_mask_t m_cmd_wmask;
  logic m_rsp_valid, m_rsp_ready, m_rsp_err;
  icb_data_t m_rsp_rdata;

  // stimulus and expectation queues
  icb_addr_t cmd_addr_q [$];
  logic cmd_read_q [$];
  icb_len_t cmd_len_q [$];
  icb_data_t wdata_q [$];
  icb_mask_t wmask_q [$];
  icb_data_t exp_data_q [$];
  logic exp_err_q [$];
  logic exp_read_q [$];
  icb_addr_t exp_addr_q [$];
  logic [7:0] ref_mem [8192];

  logic cmd_took, w_took, rsp_holdoff, timed_out;
  string test_name;
  int n_checks, n_errors;

  always #2 clk = ~clk;

  icb_unalign_bridge DUT (.*);
  icb_mem_model u_mem (.*);

  // ========================================
  // compare tasks
  // ========================================
  task automatic check_data(string what, icb_data_t exp, icb_data_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_err(string what, logic exp, logic act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_addr(string what, icb_addr_t exp, icb_addr_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  function automatic logic word_err(icb_addr_t a);
    return (a & `ICB_ERR_BASE) != 0;
  endfunction

  // one upstream request plus everything it should cause
  task automatic queue_cmd(icb_addr_t addr, logic rd, icb_len_t len);
    icb_addr_t base;
    int off, n, beats;
    logic e;
    icb_data_t w;
    icb_mask_t m;
    base = {addr[31:2], 2'b00};
    off = int'(addr[1:0]);
    n = int'(len) + 1;
    beats = n + ((off != 0) ? 1 : 0);
    cmd_addr_q.push_back(addr);
    cmd_read_q.push_back(rd);
    cmd_len_q.push_back(len);
    for (int j = 0; j < beats; j++) begin
      exp_addr_q.push_back(base + icb_addr_t'(4 * j));
    end
    if (rd) begin
      for (int k = 0; k < n; k++) begin
        for (int i = 0; i < 4; i++) begin
          w[8*i +: 8] = ref_mem[int'(addr) + 4 * k + i];
        end
        // unaligned word spans two downstream beats
        e = word_err(base + icb_addr_t'(4 * k));
        if (off != 0) e = e | word_err(base + icb_addr_t'(4 * k + 4));
        exp_data_q.push_back(w);
        exp_err_q.push_back(e);
        exp_read_q.push_back(1'b1);
      end
    end else begin
      e = 1'b0;
      for (int j = 0; j < beats; j++) begin
        e = e | word_err(base + icb_addr_t'(4 * j));
      end
      for (int k = 0; k < n; k++) begin
        w = $urandom;
        m = icb_mask_t'($urandom);
        wdata_q.push_back(w);
        wmask_q.push_back(m);
        for (int i = 0; i < 4; i++) begin
          if (m[i]) ref_mem[int'(addr) + 4 * k + i] = w[8*i +: 8];
        end
      end
      exp_data_q.push_back('0);
      exp_err_q.push_back(e);
      exp_read_q.push_back(1'b0);
    end
  endtask

  task automatic random_cmd(int lo, int span, logic rd);
    queue_cmd(icb_addr_t'(lo + int'($urandom % span)), rd, icb_len_t'($urandom));
  endtask

  // ========================================
  // drivers and monitors
  // ========================================
  always @(posedge clk) begin
    cmd_took <= sa_cmd_valid && sa_cmd_ready;
    w_took <= sa_w_valid && sa_w_ready;
    if (rst_n && m_cmd_valid && m_cmd_ready) begin
      if (exp_addr_q.size() == 0) begin
        n_errors++;
        $display("%s: downstream beat seen with no request expecting it", test_name);
      end else begin
        check_addr("m_cmd_addr", exp_addr_q.pop_front(), m_cmd_addr);
      end
    end
    if (rst_n && sa_rsp_valid && sa_rsp_ready) begin
      if (exp_data_q.size() == 0) begin
        n_errors++;
        $display("%s: upstream response arrived that was never requested", test_name);
      end else begin
        if (exp_read_q[0]) check_data("rdata", exp_data_q[0], sa_rsp_rdata);
        check_err("err", exp_err_q[0], sa_rsp_err);
        exp_data_q.delete(0);
        exp_err_q.delete(0);
        exp_read_q.delete(0);
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      if (cmd_took) sa_cmd_valid = 1'b0;
      if (!sa_cmd_valid && cmd_addr_q.size() > 0) begin
        sa_cmd_valid = 1'b1;
        sa_cmd_addr = cmd_addr_q.pop_front();
        sa_cmd_read = cmd_read_q.pop_front();
        sa_cmd_len = cmd_len_q.pop_front();
      end
      if (w_took) sa_w_valid = 1'b0;
      if (!sa_w_valid && wdata_q.size() > 0) begin
        sa_w_valid = 1'b1;
        sa_wdata = wdata_q.pop_front();
        sa_wmask = wmask_q.pop_front();
      end
      sa_rsp_ready = rsp_holdoff ? (($urandom % 3) == 0) : 1'b1;
    end
  end

  // waits until every queue and handshake has drained
  task automatic wait_drained(int max_cycles);
    int cycles;
    cycles = 0;
    while (!timed_out && (cmd_addr_q.size() > 0 || wdata_q.size() > 0 ||
           exp_data_q.size() > 0 || exp_addr_q.size() > 0 || sa_cmd_valid || sa_w_valid)) begin
      @(negedge clk);
      cycles++;
      if (cycles > max_cycles) begin
        timed_out = 1'b1;
        $display("timeout in %s: responses or beats still outstanding", test_name);
      end
    end
  endtask

  task automatic run_test(int t);
    int start_err;
    icb_addr_t a;
    start_err = n_errors;
    rsp_holdoff = 1'b0;
    case (t)
      1: begin
        test_name = "aligned_read";
        repeat (6) queue_cmd(icb_addr_t'(($urandom % 960) * 4), 1'b1, icb_len_t'($urandom));
      end
      2: begin
        test_name = "unaligned_read";
        for (int o = 0; o < 4; o++) begin
          repeat (2) random_cmd(int'(($urandom % 960) * 4) + o + 4, 1, 1'b1);
        end
      end
      3: begin
        test_name = "unaligned_write";
        for (int k = 0; k < 3; k++) begin
          a = icb_addr_t'(32'h400 + 64 * k + 1 + int'($urandom % 3));
          queue_cmd(a, 1'b0, icb_len_t'($urandom));
          // read back around the written range
          queue_cmd({a[31:2], 2'b00} - 4, 1'b1, 3'd7);
          queue_cmd({a[31:2], 2'b00} + 28, 1'b1, 3'd7);
        end
      end
      4: begin
        test_name = "cmd_addr";
        repeat (8) random_cmd(0, 32'hF00, 1'($urandom));
      end
      5: begin
        test_name = "back_to_back";
        rsp_holdoff = 1'b1;
        repeat (12) random_cmd(0, 32'hF00, 1'($urandom));
      end
      default: begin
        test_name = "error_region";
        repeat (10) random_cmd(32'hFE0, 48, 1'($urandom));
      end
    endcase
    wait_drained(3000);
    if (!timed_out) begin
      if (n_errors == start_err) $display("test %s: ok", test_name);
      else $display("test %s: %0d errors", test_name, n_errors - start_err);
    end
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    void'($urandom(32'h7073));
    rst_n = 1'b0;
    sa_cmd_valid = 1'b0;
    sa_cmd_addr = '0;
    sa_cmd_read = 1'b0;
    sa_cmd_len = '0;
    sa_w_valid = 1'b0;
    sa_wdata = '0;
    sa_wmask = '0;
    sa_rsp_ready = 1'b0;
    rsp_holdoff = 1'b0;
    timed_out = 1'b0;
    n_checks = 0;
    n_errors = 0;
    test_name = "reset";
    // same fill as the memory model
    for (int a = 0; a < 8192; a++) begin
      ref_mem[a] = 8'(a * 13 + (a >> 7));
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    for (int t = 1; t <= 6 && !timed_out; t++) begin
      run_test(t);
    end
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (!timed_out && n_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+logic
logic/icb_bridge_pkg.sv
logic/icb_cmd_queue.sv
logic/icb_beat_sequencer.sv
logic/icb_rsp_merger.sv
logic/icb_unalign_bridge.sv
test/icb_mem_model.sv
test/tb_icb_bridge.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f src.f --top-module tb_icb_bridge -o tb_sim && \
  ./obj_dir/tb_sim | tee /dev/stderr | grep -q "sim passed" && \
  echo "PASS" || { echo "FAIL"; exit 1; }
